/* design/console_pkg.sv */
`default_nettype none

package console_pkg;

    // Eight slots, fixed by the 16-bit dev_stat bus.
    localparam int NUM_SLOTS  = 8;
    localparam int SLOT_W     = $clog2(NUM_SLOTS);
    localparam int SLOT_LEN_W = 12;   // Largest slot count is 512.
    localparam int LEN_W      = 13;   // Eight full slots add up to 4096.

    // Two status bits per slot, as reported by the device side.
    typedef enum logic [1:0] {
        SLOT_IDLE  = 2'b00,   // Nothing waiting.
        SLOT_SMALL = 2'b01,   // 128 bytes.
        SLOT_MED   = 2'b10,   // 256 bytes.
        SLOT_LARGE = 2'b11    // 512 bytes.
    } slot_code_e;

    typedef enum logic [1:0] {
        XFER_IDLE  = 2'b00,
        XFER_SCAN  = 2'b01,
        XFER_BURST = 2'b10,
        XFER_DONE  = 2'b11
    } xfer_state_e;

endpackage

`default_nettype wire

/* design/console_len_if.sv */
`default_nettype none
`timescale 1ns/10ps

// Slot byte counts and their total, from the decode block to the sequencer.
interface console_len_if import console_pkg::*; ();

    logic [SLOT_LEN_W-1:0] slot_bytes [NUM_SLOTS];
    logic [LEN_W-1:0]      total_bytes;   // Lags slot_bytes by one clock.
    logic [NUM_SLOTS-1:0]  active_mask;
    logic                  changed;

    modport src (
        output slot_bytes,
        output total_bytes,
        output active_mask,
        output changed
    );

    modport dst (
        input  slot_bytes,
        input  total_bytes,
        input  active_mask,
        input  changed
    );

endinterface

`default_nettype wire

/* design/console_beat_if.sv */
`default_nettype none
`timescale 1ns/10ps

interface console_beat_if import console_pkg::*; ();

    logic              beat;       // One strobe per BEAT_BYTES bytes.
    logic [SLOT_W-1:0] slot;
    logic              slot_end;   // Marks the last beat of a slot.
    logic              done;

    modport src (
        output beat,
        output slot,
        output slot_end,
        output done
    );

    modport dst (
        input  beat,
        input  slot,
        input  slot_end,
        input  done
    );

endinterface

`default_nettype wire

/* design/console_usb_num.sv */
`default_nettype none
`timescale 1ns/10ps

module console_usb_num
    import console_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [0:2*NUM_SLOTS-1] dev_stat,
    output logic [LEN_W-1:0]       data_len,
    console_len_if.src             len
);

    logic [SLOT_LEN_W-1:0] slot_cnt  [NUM_SLOTS];
    logic [SLOT_LEN_W-1:0] slot_next [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  slot_diff;
    logic [LEN_W-1:0]      len_sum;
    logic                  changed_q;

    function automatic logic [SLOT_LEN_W-1:0] code_bytes(input slot_code_e code);
        case (code)
            SLOT_SMALL: return SLOT_LEN_W'(128);
            SLOT_MED:   return SLOT_LEN_W'(256);
            SLOT_LARGE: return SLOT_LEN_W'(512);
            default:    return '0;
        endcase
    endfunction

    // Slot i uses dev_stat[2i:2i+1], with the lower index as the high bit.
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_next[i] = code_bytes(slot_code_e'(dev_stat[2*i +: 2]));
            slot_diff[i] = (slot_next[i] != slot_cnt[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_cnt[i] <= '0;
            end
            changed_q <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_cnt[i] <= slot_next[i];
            end
            changed_q <= |slot_diff;
        end
    end

    always_comb begin
        len_sum = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            len_sum = len_sum + LEN_W'(slot_cnt[i]);
        end
    end

    // The total is taken from the registered counts, so it trails them by a clock.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_len <= '0;
        end else begin
            data_len <= len_sum;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            len.slot_bytes[i]  = slot_cnt[i];
            len.active_mask[i] = |slot_cnt[i];
        end
    end

    assign len.total_bytes = data_len;
    assign len.changed     = changed_q;

    a_len_max : assert property (@(posedge clk) disable iff (rst)
        data_len <= LEN_W'(4096))
        else $error("data_len exceeds 4096 bytes.");

endmodule

`default_nettype wire

/* design/console_xfer_sequencer.sv */
`default_nettype none
`timescale 1ns/10ps

module console_xfer_sequencer
    import console_pkg::*;
#(
    parameter int BEAT_BYTES = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        busy,
    console_len_if.dst  len,
    console_beat_if.src beats
);

    localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);

    xfer_state_e           state;
    logic [SLOT_LEN_W-1:0] snap_beats [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  pending;
    logic [NUM_SLOTS-1:0]  remain;   // Pending slots other than the one in service.
    logic [SLOT_W-1:0]     cur_slot;
    logic [SLOT_W-1:0]     next_slot;
    logic [SLOT_LEN_W-1:0] beats_left;
    logic                  last_beat;
    logic [LEN_W-1:0]      slot_sum;

    function automatic logic [SLOT_W-1:0] lowest_slot(input logic [NUM_SLOTS-1:0] mask);
        logic [SLOT_W-1:0] idx;
        idx = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = SLOT_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        last_beat = (beats_left == SLOT_LEN_W'(1));
        remain    = pending;
        if (state == XFER_BURST) begin
            remain[cur_slot] = 1'b0;
        end
        next_slot = lowest_slot(remain);
    end

    // Start counts only while busy is low, which includes the done cycle.
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                snap_beats[i] <= len.slot_bytes[i] >> BEAT_SHIFT;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= XFER_IDLE;
            pending    <= '0;
            cur_slot   <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                XFER_IDLE, XFER_DONE: begin
                    if (start) begin
                        pending <= len.active_mask;
                        state   <= XFER_SCAN;
                    end else begin
                        state <= XFER_IDLE;
                    end
                end
                XFER_SCAN: begin
                    if (remain == '0) begin
                        state <= XFER_DONE;
                    end else begin
                        cur_slot   <= next_slot;
                        beats_left <= snap_beats[next_slot];
                        state      <= XFER_BURST;
                    end
                end
                XFER_BURST: begin
                    if (last_beat) begin
                        pending[cur_slot] <= 1'b0;
                        if (remain == '0) begin
                            state <= XFER_DONE;
                        end else begin
                            cur_slot   <= next_slot;   // Next slot follows with no gap.
                            beats_left <= snap_beats[next_slot];
                        end
                    end else begin
                        beats_left <= beats_left - 1'b1;
                    end
                end
                default: state <= XFER_IDLE;
            endcase
        end
    end

    assign busy           = (state == XFER_SCAN) || (state == XFER_BURST);
    assign beats.beat     = (state == XFER_BURST);
    assign beats.slot     = cur_slot;
    assign beats.slot_end = (state == XFER_BURST) && last_beat;
    assign beats.done     = (state == XFER_DONE);

    always_comb begin
        slot_sum = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_sum = slot_sum + LEN_W'(len.slot_bytes[i]);
        end
    end

    a_idle_no_beat : assert property (@(posedge clk) disable iff (rst)
        state == XFER_IDLE |-> !beats.beat)
        else $error("Beat issued from idle.");

    a_done_alone : assert property (@(posedge clk) disable iff (rst)
        beats.done |-> !beats.beat)
        else $error("done overlaps a beat.");

    // Once the decode block has settled, its total agrees with the slot counts.
    a_total_sync : assert property (@(posedge clk) disable iff (rst)
        !len.changed |-> len.total_bytes == slot_sum)
        else $error("total_bytes out of step with slot_bytes.");

endmodule

`default_nettype wire

/* design/console_xfer_result.sv */
`default_nettype none
`timescale 1ns/10ps

module console_xfer_result
    import console_pkg::*;
#(
    parameter int BEAT_BYTES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    console_beat_if.dst          beats,
    output logic [LEN_W-1:0]     moved_bytes,
    output logic [NUM_SLOTS-1:0] served_mask
);

    logic [LEN_W-1:0]     moved_acc;
    logic [NUM_SLOTS-1:0] served_acc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            moved_acc   <= '0;
            served_acc  <= '0;
            moved_bytes <= '0;
            served_mask <= '0;
        end else if (beats.done) begin
            // Publish and start the next transfer from zero.
            moved_bytes <= moved_acc;
            served_mask <= served_acc;
            moved_acc   <= '0;
            served_acc  <= '0;
        end else begin
            if (beats.beat) begin
                moved_acc <= moved_acc + LEN_W'(BEAT_BYTES);
            end
            if (beats.slot_end) begin
                served_acc[beats.slot] <= 1'b1;   // Slot counts as served on its last beat.
            end
        end
    end

    a_end_with_beat : assert property (@(posedge clk) disable iff (rst)
        beats.slot_end |-> beats.beat)
        else $error("slot_end seen without a beat.");

endmodule

`default_nettype wire

/* design/console_usb_top.sv */
`default_nettype none
`timescale 1ns/10ps

module console_usb_top
    import console_pkg::*;
#(
    parameter int BEAT_BYTES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [0:2*NUM_SLOTS-1] dev_stat,
    input  logic                   start,
    output logic [LEN_W-1:0]       data_len,
    output logic                   busy,
    output logic                   rd_en,
    output logic [SLOT_W-1:0]      rd_slot,
    output logic                   done,
    output logic [LEN_W-1:0]       moved_bytes,
    output logic [NUM_SLOTS-1:0]   served_mask
);

    console_len_if  u_len_if ();
    console_beat_if u_beat_if ();

    console_usb_num u_usb_num (
        .clk      (clk),
        .rst      (rst),
        .dev_stat (dev_stat),
        .data_len (data_len),
        .len      (u_len_if)
    );

    console_xfer_sequencer #(
        .BEAT_BYTES (BEAT_BYTES)
    ) u_sequencer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .len   (u_len_if),
        .beats (u_beat_if)
    );

    console_xfer_result #(
        .BEAT_BYTES (BEAT_BYTES)
    ) u_result (
        .clk         (clk),
        .rst         (rst),
        .beats       (u_beat_if),
        .moved_bytes (moved_bytes),
        .served_mask (served_mask)
    );

    // The read side sees the beat strobes directly.
    assign rd_en   = u_beat_if.beat;
    assign rd_slot = u_beat_if.slot;
    assign done    = u_beat_if.done;

endmodule

`default_nettype wire

/* verif/console_usb_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module console_usb_tb import console_pkg::*; ();

    localparam int          BEAT_BYTES = 4;
    localparam int          MAX_CYCLES = 40 * 1040 + 2000;
    localparam logic [31:0] SEED       = 32'h0f89_7933;

    logic                   clk;
    logic                   rst;
    logic [0:2*NUM_SLOTS-1] dev_stat;
    logic                   start;
    logic [LEN_W-1:0]       data_len;
    logic                   busy;
    logic                   rd_en;
    logic [2:0]             rd_slot;
    logic                   done;
    logic [LEN_W-1:0]       moved_bytes;
    logic [NUM_SLOTS-1:0]   served_mask;

    // Model state.
    logic [0:2*NUM_SLOTS-1] stat_q1;   // dev_stat one edge back, as held in the slot counts.
    logic [0:2*NUM_SLOTS-1] stat_q2;   // Two edges back, as seen on data_len.
    int                     exp_slots [$];
    int                     snap_total;
    logic [NUM_SLOTS-1:0]   snap_mask;
    int                     want_moved;
    logic [NUM_SLOTS-1:0]   want_mask;
    bit                     xfer_open = 1'b0;
    bit                     res_due   = 1'b0;
    bit                     rd_en_q   = 1'b0;
    bit                     done_q    = 1'b0;
    int                     errors    = 0;
    int                     tests     = 0;
    int                     cycles    = 0;

    console_usb_top #(
        .BEAT_BYTES (BEAT_BYTES)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .dev_stat    (dev_stat),
        .start       (start),
        .data_len    (data_len),
        .busy        (busy),
        .rd_en       (rd_en),
        .rd_slot     (rd_slot),
        .done        (done),
        .moved_bytes (moved_bytes),
        .served_mask (served_mask)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Idle, small, medium and large stand for 0, 128, 256 and 512 bytes.
    function automatic int field_bytes(input logic [0:2*NUM_SLOTS-1] stat, input int slot);
        logic [1:0] code;
        code = {stat[2*slot], stat[2*slot+1]};   // Lower bit index is the high bit.
        case (code)
            2'd1:    return 128;
            2'd2:    return 256;
            2'd3:    return 512;
            default: return 0;
        endcase
    endfunction

    function automatic int stat_total(input logic [0:2*NUM_SLOTS-1] stat);
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            sum += field_bytes(stat, i);
        end
        return sum;
    endfunction

    task automatic take_snapshot();
        int bytes;
        snap_total = 0;
        snap_mask  = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            bytes = field_bytes(stat_q1, i);
            snap_total += bytes;
            snap_mask[i] = (bytes != 0);
            for (int b = 0; b < bytes / BEAT_BYTES; b++) begin
                exp_slots.push_back(i);
            end
        end
        xfer_open = 1'b1;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            stat_q1 <= '0;
            stat_q2 <= '0;
        end else begin
            stat_q1 <= dev_stat;
            stat_q2 <= stat_q1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (!rst) begin
            assert (data_len == LEN_W'(stat_total(stat_q2))) else begin
                $display("Error at %0t: data_len is %0d, expected %0d.",
                         $time, data_len, stat_total(stat_q2));
                errors++;
            end
            if (res_due) begin
                assert (moved_bytes == LEN_W'(want_moved) && served_mask == want_mask) else begin
                    $display("Error at %0t: result %0d bytes mask %b, expected %0d bytes mask %b.",
                             $time, moved_bytes, served_mask, want_moved, want_mask);
                    errors++;
                end
                res_due = 1'b0;
            end
            if (rd_en) begin
                assert (exp_slots.size() > 0 && busy) else begin
                    $display("Error at %0t: rd_en high with no beat expected.", $time);
                    errors++;
                end
                if (exp_slots.size() > 0) begin
                    assert (rd_slot == 3'(exp_slots[0])) else begin
                        $display("Error at %0t: rd_slot is %0d, expected %0d.",
                                 $time, rd_slot, exp_slots[0]);
                        errors++;
                    end
                    exp_slots.delete(0);
                end
            end
            assert (!(rd_en_q && !rd_en) || done) else begin
                $display("Error at %0t: rd_en dropped before the last beat.", $time);
                errors++;
            end
            if (done) begin
                assert (xfer_open && exp_slots.size() == 0 && !done_q) else begin
                    $display("Error at %0t: done out of place, %0d beats still expected.",
                             $time, exp_slots.size());
                    errors++;
                end
                want_moved = snap_total;
                want_mask  = snap_mask;
                res_due    = 1'b1;
                xfer_open  = 1'b0;
            end
            // The engine is busy from the edge that takes start until done.
            assert (busy == xfer_open) else begin
                $display("Error at %0t: busy is %0b, expected %0b.", $time, busy, xfer_open);
                errors++;
            end
            if (!xfer_open && start) begin
                take_snapshot();
            end
            rd_en_q = rd_en;
            done_q  = done;
        end
    end

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic check_idle(input string when);
        assert (data_len == '0 && !busy && !rd_en && !done
                && moved_bytes == '0 && served_mask == '0) else begin
            $display("Error at %0t: outputs not at their reset values %s.", $time, when);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int base);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - base);
    endtask

    task automatic run_transfer(input logic [0:2*NUM_SLOTS-1] stat, input bit disturb);
        dev_stat = stat;
        next_edge();
        next_edge();
        start = 1'b1;
        next_edge();
        start = 1'b0;
        while (xfer_open) begin
            if (disturb && exp_slots.size() > 0) begin   // Engine is busy in this cycle.
                dev_stat = 16'($urandom);
                start    = ($urandom_range(0, 2) == 0);
            end else begin
                start = 1'b0;
            end
            next_edge();
        end
        start = 1'b0;
        next_edge();
    endtask

    initial begin
        int base;
        void'($urandom(SEED));
        rst      = 1'b1;
        start    = 1'b0;
        dev_stat = '0;

        base = errors;
        repeat (10) begin
            @(negedge clk);
            check_idle("during reset");
        end
        next_edge();
        rst = 1'b0;
        @(negedge clk);
        check_idle("after reset");
        next_edge();
        report_test("reset state", base);

        base = errors;
        repeat (200) begin
            dev_stat = 16'($urandom);
            repeat (2 + $urandom_range(0, 1)) begin
                next_edge();
            end
        end
        report_test("length decode", base);

        base = errors;
        repeat (30) begin
            run_transfer(16'($urandom), 1'b0);
        end
        report_test("transfer sequence and results", base);

        base = errors;
        repeat (8) begin
            run_transfer(16'($urandom), 1'b1);
        end
        report_test("ignored start and mid-transfer changes", base);

        base = errors;
        run_transfer('0, 1'b0);
        report_test("empty transfer", base);

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* console_usb.f */
design/console_pkg.sv
design/console_len_if.sv
design/console_beat_if.sv
design/console_usb_num.sv
design/console_xfer_sequencer.sv
design/console_xfer_result.sv
design/console_usb_top.sv
verif/console_usb_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; the exit status follows the testbench verdict.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f console_usb.f --top-module console_usb_tb \
    && ./obj_dir/Vconsole_usb_tb | tee /dev/stderr \
    | grep -q "Simulation finished: PASS" \
    && exit 0 || exit 1
